//--- list.f
common/pov_pkg.sv
rtl/spi_frame_receiver.sv
rtl/command_decoder.sv
rtl/frame_timer.sv
driver/led_driver_shifter.sv
rtl/pov_display_top.sv
testbench/pov_display_assert.sv
testbench/tb_pov_display.sv

//--- run.sh
#!/bin/sh
# Build and run the POV display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pov_display -f list.f -o pov_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pov_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1

//--- testbench/tb_pov_display.sv
`timescale 1ns/10ps

module tb_pov_display;

    // One rotation in clk cycles
    localparam int FRAME_CYCLES = pov_pkg::CLK_DIV * pov_pkg::FRAME_TICKS;
    localparam int HALF_SCLK    = 8;
    // Longest SPI transfer, with chip-select setup and gap
    localparam int XFER_CYCLES  = pov_pkg::MAX_BYTES * 16 * HALF_SCLK + 4 * HALF_SCLK;
    // 43 transfers and about 7 frame periods of waiting, with margin
    localparam int TIMEOUT_CYCLES = 45 * XFER_CYCLES + 9 * FRAME_CYCLES;
    // Ticks watched for the running grayscale clock
    localparam int GCLK_TICKS = 16;

    // Bits seen by each lane between two latches
    typedef struct packed {
        logic [pov_pkg::LANES-1:0][pov_pkg::CONF_W-1:0] words;
        logic [7:0]                                     nbits;
        // col_out at the first serial clock edge of this record
        pov_pkg::col_mask_t                             hold_col;
        pov_pkg::col_mask_t                             col;
    } latch_rec_t;

    logic                clk;
    logic                rst_n;
    logic                spi_cs_n;
    logic                spi_sclk;
    logic                spi_mosi;
    logic                spi_miso;
    pov_pkg::lane_bits_t drv_sin;
    logic                drv_sclk;
    logic                drv_lat;
    logic                drv_gclk;
    pov_pkg::col_mask_t  col_out;

    latch_rec_t     cur_rec;
    latch_rec_t     recs [$];
    int             sclk_edges;
    logic           sclk_seen;
    logic           lat_seen;
    logic [31:0]    lfsr_state;
    pov_pkg::pixel_t pix_ref [pov_pkg::COLUMNS][pov_pkg::LANES];
    int             err_count;
    int             test_start_errs;
    int             tests_run;
    int             tests_failed;
    int             assert_fails;
    int             cycle_count;

    pov_display_top u_pov_display_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .drv_sin  (drv_sin),
        .drv_sclk (drv_sclk),
        .drv_lat  (drv_lat),
        .drv_gclk (drv_gclk),
        .col_out  (col_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Driver bus monitor on the falling clk edge, outputs settled there
    always @(negedge clk) begin
        if (!rst_n) begin
            cur_rec    = '0;
            sclk_edges = 0;
            sclk_seen  = 1'b0;
            lat_seen   = 1'b0;
        end else begin
            if (drv_sclk && !sclk_seen) begin
                if (cur_rec.nbits == 8'd0) begin
                    cur_rec.hold_col = col_out;
                end
                for (int l = 0; l < pov_pkg::LANES; l++) begin
                    cur_rec.words[l] = {cur_rec.words[l][pov_pkg::CONF_W-2:0], drv_sin[l]};
                end
                cur_rec.nbits = cur_rec.nbits + 8'd1;
                sclk_edges    = sclk_edges + 1;
            end
            if (drv_lat && !lat_seen) begin
                cur_rec.col = col_out;
                recs.push_back(cur_rec);
                cur_rec = '0;
            end
            sclk_seen = drv_sclk;
            lat_seen  = drv_lat;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // Mode 0 master, first byte in data[39:32], MISO taken on each SCLK rise
    task automatic spi_xfer(input logic [39:0] data, input int nbytes,
                            output pov_pkg::status_t rx);
        rx = '0;
        spi_cs_n <= 1'b0;
        wait_cycles(HALF_SCLK);
        for (int i = 0; i < nbytes * 8; i++) begin
            spi_mosi <= data[39-i];
            wait_cycles(HALF_SCLK);
            if (i < pov_pkg::STATUS_W) begin
                rx = {rx[pov_pkg::STATUS_W-2:0], spi_miso};
            end
            spi_sclk <= 1'b1;
            wait_cycles(HALF_SCLK);
            spi_sclk <= 1'b0;
        end
        wait_cycles(HALF_SCLK);
        spi_cs_n <= 1'b1;
        wait_cycles(2 * HALF_SCLK);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count != test_start_errs) begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - test_start_errs);
        end else begin
            $display("test %s: ok", name);
        end
        test_start_errs = err_count;
    endtask

    // Two frame periods without serial clock edges or grayscale clock
    task automatic expect_quiet(input string name);
        int edges_before;
        int gclk_high;
        edges_before = sclk_edges;
        gclk_high    = 0;
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(posedge clk);
            if (drv_gclk !== 1'b0) begin
                gclk_high++;
            end
        end
        if (gclk_high != 0) begin
            $display("%s: grayscale clock high for %0d cycles while disabled", name, gclk_high);
            err_count++;
        end
        if (sclk_edges != edges_before) begin
            $display("%s: %0d driver serial clock edges while disabled", name,
                     sclk_edges - edges_before);
            err_count++;
        end
    endtask

    // Enabled grayscale clock changes level once per tick
    task automatic expect_gclk_toggle(input string name);
        int   toggles;
        logic prev;
        toggles = 0;
        @(negedge clk);
        prev = drv_gclk;
        for (int i = 0; i < GCLK_TICKS * pov_pkg::CLK_DIV; i++) begin
            @(negedge clk);
            if (drv_gclk !== prev) begin
                toggles++;
            end
            prev = drv_gclk;
        end
        if (toggles != GCLK_TICKS) begin
            $display("mismatch %s: grayscale clock toggles expected %0d actual %0d", name,
                     GCLK_TICKS, toggles);
            err_count++;
        end
        @(posedge clk);
    endtask

    // One full scan, data per lane and the masked column at each latch
    task automatic verify_scan(input string name, input pov_pkg::col_mask_t mask);
        latch_rec_t         rec;
        pov_pkg::col_mask_t exp_col;
        pov_pkg::col_mask_t exp_hold;
        recs.delete();
        while (recs.size() < pov_pkg::COLUMNS) @(posedge clk);
        for (int c = 0; c < pov_pkg::COLUMNS; c++) begin
            rec     = recs[c];
            exp_col = mask & (pov_pkg::col_mask_t'(1) << c);
            // Previous column stays lit while this one shifts, none before column 0
            exp_hold = (c == 0) ? '0 : (mask & (pov_pkg::col_mask_t'(1) << (c - 1)));
            if (rec.nbits != 8'(pov_pkg::PIX_W)) begin
                $display("mismatch %s: col %0d bit count expected %0d actual %0d", name, c,
                         pov_pkg::PIX_W, rec.nbits);
                err_count++;
            end
            if (rec.col !== exp_col) begin
                $display("mismatch %s: col %0d col_out expected %h actual %h", name, c,
                         exp_col, rec.col);
                err_count++;
            end
            if (rec.hold_col !== exp_hold) begin
                $display("mismatch %s: col %0d col_out while shifting expected %h actual %h",
                         name, c, exp_hold, rec.hold_col);
                err_count++;
            end
            for (int l = 0; l < pov_pkg::LANES; l++) begin
                if (rec.words[l][pov_pkg::PIX_W-1:0] !== pix_ref[c][l]) begin
                    $display("mismatch %s: col %0d lane %0d expected %h actual %h", name, c, l,
                             pix_ref[c][l], rec.words[l][pov_pkg::PIX_W-1:0]);
                    err_count++;
                end
            end
        end
    endtask

    task automatic check_reset_state();
        if ({drv_sin, drv_sclk, drv_lat, drv_gclk, col_out, spi_miso} !== '0) begin
            $display("mismatch reset: outputs expected 0 actual %h",
                     {drv_sin, drv_sclk, drv_lat, drv_gclk, col_out, spi_miso});
            err_count++;
        end
        expect_quiet("reset");
        finish_test("reset");
    endtask

    task automatic readback_status();
        pov_pkg::status_t rx;
        spi_xfer({pov_pkg::OP_MASK, 8'hA5, 24'h0}, 2, rx);
        spi_xfer({pov_pkg::OP_ENABLE, 8'h01, 24'h0}, 2, rx);
        spi_xfer(40'h0, 2, rx);
        if (rx !== 16'hA501) begin
            $display("mismatch status: readback expected %h actual %h", 16'hA501, rx);
            err_count++;
        end
        // Mask frame one byte too long, must not take effect
        spi_xfer({pov_pkg::OP_MASK, 8'h5A, 8'h00, 16'h0}, 3, rx);
        spi_xfer(40'h0, 2, rx);
        if (rx !== 16'hA501) begin
            $display("mismatch status: readback after bad frame expected %h actual %h",
                     16'hA501, rx);
            err_count++;
        end
        spi_xfer({pov_pkg::OP_MASK, 8'hFF, 24'h0}, 2, rx);
        finish_test("status");
    endtask

    task automatic shift_config();
        logic [31:0]      word;
        pov_pkg::status_t rx;
        latch_rec_t       rec;
        word = random_bits(pov_pkg::CONF_W);
        recs.delete();
        spi_xfer({pov_pkg::OP_CONFIG, word}, 5, rx);
        // Column latches of a running scan light a column, the config latch does not
        rec = '1;
        while (rec.col !== '0) begin
            @(posedge clk);
            if (recs.size() > 0) begin
                rec = recs.pop_front();
            end
        end
        if (rec.nbits != 8'(pov_pkg::CONF_W)) begin
            $display("mismatch config: bit count expected %0d actual %0d", pov_pkg::CONF_W,
                     rec.nbits);
            err_count++;
        end
        if (rec.hold_col !== '0) begin
            $display("mismatch config: col_out while shifting expected %h actual %h",
                     8'h00, rec.hold_col);
            err_count++;
        end
        for (int l = 0; l < pov_pkg::LANES; l++) begin
            if (rec.words[l] !== word) begin
                $display("mismatch config: lane %0d expected %h actual %h", l, word,
                         rec.words[l]);
                err_count++;
            end
        end
        finish_test("config");
    endtask

    task automatic scan_columns();
        pov_pkg::status_t rx;
        logic [31:0]      value;
        // Stop scanning so no scan runs on half-written pixels
        spi_xfer({pov_pkg::OP_ENABLE, 8'h00, 24'h0}, 2, rx);
        for (int c = 0; c < pov_pkg::COLUMNS; c++) begin
            for (int l = 0; l < pov_pkg::LANES; l++) begin
                value = random_bits(pov_pkg::PIX_W);
                pix_ref[c][l] = value[pov_pkg::PIX_W-1:0];
                spi_xfer({pov_pkg::OP_PIXEL, 8'(c), 8'(l), value[15:0]}, 5, rx);
            end
        end
        spi_xfer({pov_pkg::OP_ENABLE, 8'h01, 24'h0}, 2, rx);
        verify_scan("scan", 8'hFF);
        expect_gclk_toggle("scan");
        finish_test("scan");
    endtask

    task automatic mask_and_disable();
        pov_pkg::status_t rx;
        spi_xfer({pov_pkg::OP_MASK, 8'h0F, 24'h0}, 2, rx);
        verify_scan("mask", 8'h0F);
        spi_xfer({pov_pkg::OP_ENABLE, 8'h00, 24'h0}, 2, rx);
        // Next tick pulls the grayscale clock low
        wait_cycles(2 * pov_pkg::CLK_DIV);
        expect_quiet("disable");
        finish_test("mask");
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        spi_cs_n        = 1'b1;
        spi_sclk        = 1'b0;
        spi_mosi        = 1'b0;
        lfsr_state      = 32'd68789;
        err_count       = 0;
        test_start_errs = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_state();
        readback_status();
        shift_config();
        scan_columns();
        mask_and_disable();
        assert_fails = u_pov_display_top.u_led_driver_shifter.u_pov_display_assert.fail_count;
        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/pov_display_assert.sv
`timescale 1ns/10ps

module pov_display_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               tick,
    input logic               scan_enable,
    input logic               drv_sclk,
    input logic               drv_lat,
    input logic               drv_gclk,
    input pov_pkg::col_mask_t col_sel
);

    // Number of failed checks so far
    int fail_count = 0;

    // Drivers latch only with the serial clock low
    lat_sclk_a: assert property (@(posedge clk) disable iff (!rst_n) !(drv_lat && drv_sclk))
        else begin
            fail_count++;
            $error("driver latch high while driver serial clock high");
        end

    // At most one column lit, a new column appears only with its latch
    col_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(col_sel) && (!$changed(col_sel) || drv_lat || (col_sel == '0)))
        else begin
            fail_count++;
            $error("column select not one-hot or changed outside a latch");
        end

    // Grayscale clock falls on the first tick after disable and then holds low
    gclk_off_a: assert property (@(posedge clk) disable iff (!rst_n)
        (!scan_enable && (tick || !drv_gclk)) |=> !drv_gclk)
        else begin
            fail_count++;
            $error("grayscale clock running while the scan is disabled");
        end

endmodule

bind led_driver_shifter pov_display_assert u_pov_display_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .tick        (tick),
    .scan_enable (scan_enable),
    .drv_sclk    (drv_sclk),
    .drv_lat     (drv_lat),
    .drv_gclk    (drv_gclk),
    .col_sel     (col_sel)
);

//--- rtl/pov_display_top.sv
`timescale 1ns/10ps

module pov_display_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                spi_cs_n,
    input  logic                spi_sclk,
    input  logic                spi_mosi,
    output logic                spi_miso,
    output pov_pkg::lane_bits_t drv_sin,
    output logic                drv_sclk,
    output logic                drv_lat,
    output logic                drv_gclk,
    output pov_pkg::col_mask_t  col_out
);

    // Host command path
    pov_pkg::spi_frame_t   frame;
    logic                  frame_valid;
    pov_pkg::status_t      status;

    // Display state
    pov_pkg::conf_t        conf;
    logic                  start_config;
    pov_pkg::col_mask_t    col_mask;
    logic                  scan_enable;
    pov_pkg::pixel_frame_t pixels;

    // Timing and column select
    logic                  tick;
    logic                  sof;
    pov_pkg::col_mask_t    col_sel;

    spi_frame_receiver u_spi_frame_receiver (
        .clk         (clk),
        .rst_n       (rst_n),
        .spi_cs_n    (spi_cs_n),
        .spi_sclk    (spi_sclk),
        .spi_mosi    (spi_mosi),
        .status      (status),
        .spi_miso    (spi_miso),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    command_decoder u_command_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame        (frame),
        .frame_valid  (frame_valid),
        .conf         (conf),
        .start_config (start_config),
        .col_mask     (col_mask),
        .scan_enable  (scan_enable),
        .pixels       (pixels),
        .status       (status)
    );

    frame_timer u_frame_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .sof   (sof)
    );

    led_driver_shifter u_led_driver_shifter (
        .clk          (clk),
        .rst_n        (rst_n),
        .tick         (tick),
        .sof          (sof),
        .start_config (start_config),
        .conf         (conf),
        .scan_enable  (scan_enable),
        .pixels       (pixels),
        .drv_sin      (drv_sin),
        .drv_sclk     (drv_sclk),
        .drv_lat      (drv_lat),
        .drv_gclk     (drv_gclk),
        .col_sel      (col_sel)
    );

    // Masked columns stay dark, data still shifts
    assign col_out = col_sel & col_mask;

endmodule

//--- driver/led_driver_shifter.sv
`timescale 1ns/10ps

module led_driver_shifter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  logic                  sof,
    input  logic                  start_config,
    input  pov_pkg::conf_t        conf,
    input  logic                  scan_enable,
    input  pov_pkg::pixel_frame_t pixels,
    output pov_pkg::lane_bits_t   drv_sin,
    output logic                  drv_sclk,
    output logic                  drv_lat,
    output logic                  drv_gclk,
    output pov_pkg::col_mask_t    col_sel
);

    pov_pkg::shift_state_t       state;
    logic [pov_pkg::BIT_W-1:0]   bit_cnt;
    logic [pov_pkg::COL_W-1:0]   col_cnt;
    // Low half of a bit is phase 0, SCLK high is phase 1
    logic                        phase;
    logic                        cfg_pending;

    // Lane bits for a given sequence, column and bit position
    function automatic pov_pkg::lane_bits_t bits_at(
        input pov_pkg::shift_state_t   st,
        input logic [pov_pkg::COL_W-1:0] c,
        input logic [pov_pkg::BIT_W-1:0] b
    );
        pov_pkg::lane_bits_t bits;
        bits = '0;
        if (st == pov_pkg::CONF_SHIFT) begin
            // Same config bit on every lane
            bits = {pov_pkg::LANES{conf[b]}};
        end else begin
            for (int l = 0; l < pov_pkg::LANES; l++) begin
                bits[l] = pixels[c][l][b[pov_pkg::PIX_IDX_W-1:0]];
            end
        end
        return bits;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= pov_pkg::IDLE;
            bit_cnt     <= '0;
            col_cnt     <= '0;
            phase       <= 1'b0;
            cfg_pending <= 1'b0;
            drv_sin     <= '0;
            drv_sclk    <= 1'b0;
            drv_lat     <= 1'b0;
            drv_gclk    <= 1'b0;
            col_sel     <= '0;
        end else begin
            if (tick) begin
                // Grayscale clock runs only while enabled
                drv_gclk <= scan_enable ? ~drv_gclk : 1'b0;
                case (state)
                    pov_pkg::IDLE: begin
                        if (cfg_pending) begin
                            // Config has priority, columns off while it shifts
                            state       <= pov_pkg::CONF_SHIFT;
                            cfg_pending <= 1'b0;
                            bit_cnt     <= pov_pkg::CONF_TOP;
                            phase       <= 1'b0;
                            col_sel     <= '0;
                            drv_sin     <= bits_at(pov_pkg::CONF_SHIFT, '0, pov_pkg::CONF_TOP);
                        end else if (sof) begin
                            col_sel <= '0;
                            if (scan_enable) begin
                                state   <= pov_pkg::COL_SHIFT;
                                col_cnt <= '0;
                                bit_cnt <= pov_pkg::PIX_TOP;
                                phase   <= 1'b0;
                                drv_sin <= bits_at(pov_pkg::COL_SHIFT, '0, pov_pkg::PIX_TOP);
                            end
                        end
                    end
                    pov_pkg::CONF_SHIFT,
                    pov_pkg::COL_SHIFT: begin
                        if (!phase) begin
                            drv_sclk <= 1'b1;
                            phase    <= 1'b1;
                        end else begin
                            drv_sclk <= 1'b0;
                            phase    <= 1'b0;
                            if (bit_cnt == '0) begin
                                // Last bit clocked, latch on the following tick
                                drv_lat <= 1'b1;
                                drv_sin <= '0;
                                if (state == pov_pkg::CONF_SHIFT) begin
                                    state <= pov_pkg::CONF_LATCH;
                                end else begin
                                    state   <= pov_pkg::COL_LATCH;
                                    col_sel <= pov_pkg::col_mask_t'(1'b1) << col_cnt;
                                end
                            end else begin
                                bit_cnt <= bit_cnt - 1'b1;
                                drv_sin <= bits_at(state, col_cnt, bit_cnt - 1'b1);
                            end
                        end
                    end
                    pov_pkg::CONF_LATCH: begin
                        drv_lat <= 1'b0;
                        state   <= pov_pkg::IDLE;
                    end
                    pov_pkg::COL_LATCH: begin
                        drv_lat <= 1'b0;
                        if (col_cnt == pov_pkg::COL_LAST) begin
                            // Last column stays selected until the next SOF
                            state <= pov_pkg::IDLE;
                        end else begin
                            state   <= pov_pkg::COL_SHIFT;
                            col_cnt <= col_cnt + 1'b1;
                            bit_cnt <= pov_pkg::PIX_TOP;
                            phase   <= 1'b0;
                            drv_sin <= bits_at(pov_pkg::COL_SHIFT, col_cnt + 1'b1,
                                               pov_pkg::PIX_TOP);
                        end
                    end
                    default: state <= pov_pkg::IDLE;
                endcase
            end
            // Config request held until the shifter is idle
            if (start_config) begin
                cfg_pending <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/frame_timer.sv
`timescale 1ns/10ps

module frame_timer (
    input  logic clk,
    input  logic rst_n,
    output logic tick,
    output logic sof
);

    logic [pov_pkg::DIV_W-1:0]   div_cnt;
    logic [pov_pkg::FRAME_W-1:0] frame_cnt;

    // Clock-enable divider, one tick every CLK_DIV cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == pov_pkg::DIV_LAST) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    // Stands in for the Hall sensor, counts ticks per revolution
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (tick) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // Coincides with the last tick of each period
    assign sof = tick & (frame_cnt == pov_pkg::FRAME_LAST);

endmodule

//--- rtl/command_decoder.sv
`timescale 1ns/10ps

module command_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pov_pkg::spi_frame_t   frame,
    input  logic                  frame_valid,
    output pov_pkg::conf_t        conf,
    output logic                  start_config,
    output pov_pkg::col_mask_t    col_mask,
    output logic                  scan_enable,
    output pov_pkg::pixel_frame_t pixels,
    output pov_pkg::status_t      status
);

    // Frame bytes, opcode first
    logic [7:0] opcode;
    logic [7:0] arg0;
    logic [7:0] arg1;
    logic [7:0] arg2;
    logic [7:0] arg3;
    logic       pix_in_range;

    assign opcode = frame.payload[39:32];
    assign arg0   = frame.payload[31:24];
    assign arg1   = frame.payload[23:16];
    assign arg2   = frame.payload[15:8];
    assign arg3   = frame.payload[7:0];

    // Column in arg0, lane in arg1, upper bits must be clear
    assign pix_in_range = (arg0[7:pov_pkg::COL_W] == '0) && (arg1[7:pov_pkg::LANE_W] == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conf         <= '0;
            start_config <= 1'b0;
            col_mask     <= '1;
            scan_enable  <= 1'b0;
            pixels       <= '0;
        end else begin
            start_config <= 1'b0;
            if (frame_valid) begin
                // Length mismatch or unknown opcode drops the frame
                case (opcode)
                    pov_pkg::OP_CONFIG: begin
                        if (frame.len_bytes == pov_pkg::LEN_CONFIG) begin
                            conf         <= frame.payload[pov_pkg::CONF_W-1:0];
                            start_config <= 1'b1;
                        end
                    end
                    pov_pkg::OP_MASK: begin
                        if (frame.len_bytes == pov_pkg::LEN_MASK) begin
                            col_mask <= arg0;
                        end
                    end
                    pov_pkg::OP_ENABLE: begin
                        if (frame.len_bytes == pov_pkg::LEN_ENABLE) begin
                            scan_enable <= arg0[0];
                        end
                    end
                    pov_pkg::OP_PIXEL: begin
                        if ((frame.len_bytes == pov_pkg::LEN_PIXEL) && pix_in_range) begin
                            pixels[arg0[pov_pkg::COL_W-1:0]][arg1[pov_pkg::LANE_W-1:0]] <=
                                {arg2, arg3};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Readback word, mask on top and enable in bit 0
    assign status = {col_mask, {(pov_pkg::STATUS_W - pov_pkg::COLUMNS - 1){1'b0}}, scan_enable};

endmodule

//--- rtl/spi_frame_receiver.sv
`timescale 1ns/10ps

module spi_frame_receiver (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                spi_cs_n,
    input  logic                spi_sclk,
    input  logic                spi_mosi,
    input  pov_pkg::status_t    status,
    output logic                spi_miso,
    output pov_pkg::spi_frame_t frame,
    output logic                frame_valid
);

    // Two-flop synchronisers, index 1 is the safe copy
    logic [1:0] cs_sync;
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    // Previous synchronised levels for edge detection
    logic cs_q;
    logic sclk_q;

    logic cs_fall;
    logic cs_rise;
    logic sclk_rise;
    logic sclk_fall;
    logic byte_done;

    logic [2:0]                  bit_cnt;
    logic [6:0]                  byte_sr;
    logic [7:0]                  rx_byte;
    logic [pov_pkg::LEN_W-1:0]   byte_cnt;
    logic [pov_pkg::MAX_BYTES*8-1:0] payload;
    pov_pkg::status_t            status_sr;

    assign cs_fall   = cs_q & ~cs_sync[1];
    assign cs_rise   = ~cs_q & cs_sync[1];
    // SCLK edges only count while selected
    assign sclk_rise = ~cs_sync[1] & sclk_sync[1] & ~sclk_q;
    assign sclk_fall = ~cs_sync[1] & ~sclk_sync[1] & sclk_q;
    // Byte including the bit sampled on this edge
    assign rx_byte   = {byte_sr, mosi_sync[1]};
    assign byte_done = sclk_rise & (bit_cnt == 3'd7);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync     <= 2'b11;
            sclk_sync   <= 2'b00;
            mosi_sync   <= 2'b00;
            cs_q        <= 1'b1;
            sclk_q      <= 1'b0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            spi_miso    <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            cs_sync     <= {cs_sync[0], spi_cs_n};
            sclk_sync   <= {sclk_sync[0], spi_sclk};
            mosi_sync   <= {mosi_sync[0], spi_mosi};
            cs_q        <= cs_sync[1];
            sclk_q      <= sclk_sync[1];
            frame_valid <= 1'b0;
            if (cs_fall) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
                // Mode 0, first status bit must be out before the first rise
                spi_miso <= status[pov_pkg::STATUS_W-1];
            end else if (cs_rise) begin
                // Publish only frames with at least one whole byte
                frame_valid <= (byte_cnt != '0);
                spi_miso    <= 1'b0;
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
                // Count saturates at the longest frame
                if (byte_done && (byte_cnt != pov_pkg::MAX_LEN)) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
                if (sclk_fall) begin
                    spi_miso <= status_sr[pov_pkg::STATUS_W-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_fall) begin
            payload   <= '0;
            // Status snapshot, MSB already on MISO
            status_sr <= {status[pov_pkg::STATUS_W-2:0], 1'b0};
        end else begin
            if (sclk_rise) begin
                byte_sr <= rx_byte[6:0];
            end
            // Bytes fill the payload from the top down
            if (byte_done && (byte_cnt != pov_pkg::MAX_LEN)) begin
                payload[(pov_pkg::MAX_BYTES - 1 - int'(byte_cnt)) * 8 +: 8] <= rx_byte;
            end
            if (sclk_fall) begin
                status_sr <= {status_sr[pov_pkg::STATUS_W-2:0], 1'b0};
            end
        end
        if (cs_rise) begin
            frame.payload   <= payload;
            frame.len_bytes <= byte_cnt;
        end
    end

endmodule

//--- common/pov_pkg.sv
package pov_pkg;

    // Display geometry
    localparam int LANES   = 4;
    localparam int COLUMNS = 8;
    localparam int PIX_W   = 16;
    localparam int CONF_W  = 32;

    // Tick divider and emulated rotation period, in ticks
    localparam int CLK_DIV     = 4;
    localparam int FRAME_TICKS = 1024;

    // SPI side
    localparam int STATUS_W  = 16;
    localparam int MAX_BYTES = 5;

    // Derived index and counter widths
    localparam int COL_W     = $clog2(COLUMNS);
    localparam int LANE_W    = $clog2(LANES);
    localparam int BIT_W     = $clog2(CONF_W);
    localparam int PIX_IDX_W = $clog2(PIX_W);
    localparam int DIV_W     = $clog2(CLK_DIV);
    localparam int FRAME_W   = $clog2(FRAME_TICKS);
    localparam int LEN_W     = $clog2(MAX_BYTES + 1);

    // Terminal counts, sized to their counters
    localparam logic [DIV_W-1:0]   DIV_LAST   = DIV_W'(CLK_DIV - 1);
    localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(FRAME_TICKS - 1);
    localparam logic [COL_W-1:0]   COL_LAST   = COL_W'(COLUMNS - 1);
    localparam logic [BIT_W-1:0]   CONF_TOP   = BIT_W'(CONF_W - 1);
    localparam logic [BIT_W-1:0]   PIX_TOP    = BIT_W'(PIX_W - 1);
    localparam logic [LEN_W-1:0]   MAX_LEN    = LEN_W'(MAX_BYTES);

    // Opcodes, first byte of every frame
    localparam logic [7:0] OP_CONFIG = 8'h01;
    localparam logic [7:0] OP_MASK   = 8'h02;
    localparam logic [7:0] OP_ENABLE = 8'h03;
    localparam logic [7:0] OP_PIXEL  = 8'h10;

    // Expected frame lengths, opcode byte included
    localparam logic [LEN_W-1:0] LEN_CONFIG = 3'd5;
    localparam logic [LEN_W-1:0] LEN_MASK   = 3'd2;
    localparam logic [LEN_W-1:0] LEN_ENABLE = 3'd2;
    localparam logic [LEN_W-1:0] LEN_PIXEL  = 3'd5;

    typedef logic [PIX_W-1:0]    pixel_t;
    typedef logic [CONF_W-1:0]   conf_t;
    typedef logic [COLUMNS-1:0]  col_mask_t;
    typedef logic [LANES-1:0]    lane_bits_t;
    typedef logic [STATUS_W-1:0] status_t;

    // First received byte sits in the top bits of payload
    typedef struct packed {
        logic [MAX_BYTES*8-1:0] payload;
        logic [LEN_W-1:0]       len_bytes;
    } spi_frame_t;

    // Indexed as [column][lane]
    typedef pixel_t [COLUMNS-1:0][LANES-1:0] pixel_frame_t;

    typedef enum logic [2:0] {
        IDLE,
        CONF_SHIFT,
        CONF_LATCH,
        COL_SHIFT,
        COL_LATCH
    } shift_state_t;

endpackage
